/* logic/pfifo_pkg.sv */
// packet FIFO shared definitions
// packet word layout, payload width and eop crossing constants
// used by storage, read control and the crossings

package pfifo_pkg;

    // ------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------
    localparam int DATA_W      = 16;  // payload bits per word
    localparam int NUM_BANKS   = 2;   // storage banks, used alternately

    // eop crossing
    localparam int EOP_STRETCH = 16;  // wclock cycles the eop level is held
    localparam int EOP_GAP     = 20;  // min wclock cycles between eop writes

    // ------------------------------------------------------------------
    // packet word, 18 bits
    // sop on top, then eop, then payload
    // ------------------------------------------------------------------
    typedef struct packed {
        logic              sop;   // first word of packet
        logic              eop;   // last word of packet
        logic [DATA_W-1:0] data;  // payload
    } pkt_word_t;

endpackage

/* logic/pkt_ram_bank.sv */
// banked packet storage
// NUM_BANKS simple dual-port arrays, write in wclock, read in rclock
// every bank is read at rd_addr each rclock, output picked by the
// registered bank select

module pkt_ram_bank import pfifo_pkg::*; #(
    parameter int BANK_DEPTH = 1024
) (
    input  logic                          wclock,
    input  logic                          rclock,
    input  logic                          wr_en,
    input  logic                          wr_bank,
    input  logic [$clog2(BANK_DEPTH)-1:0] wr_addr,
    input  pkt_word_t                     wr_word,
    input  logic                          rd_bank,
    input  logic [$clog2(BANK_DEPTH)-1:0] rd_addr,
    output pkt_word_t                     rd_word
);

    pkt_word_t mem   [NUM_BANKS][BANK_DEPTH];  // one array per bank
    pkt_word_t rd_q  [NUM_BANKS];              // per-bank read register
    logic      rd_bank_d1;                     // bank of the registered read

    // ------------------------------------------------------------------
    // write port
    // ------------------------------------------------------------------
    always_ff @(posedge wclock) begin
        if (wr_en) begin
            mem[wr_bank][wr_addr] <= wr_word;  // only the selected bank
        end
    end

    // ------------------------------------------------------------------
    // read port
    // ------------------------------------------------------------------
    // one rclock from address to word
    always_ff @(posedge rclock) begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            rd_q[b] <= mem[b][rd_addr];
        end
    end

    // bank select lines up with the data it chooses
    always_ff @(posedge rclock) begin
        rd_bank_d1 <= rd_bank;
    end

    // output mux
    always_comb begin
        rd_word = rd_q[rd_bank_d1];
    end

endmodule

/* logic/wr_ctrl.sv */
// write side control
// bank address counter with bank toggle at the last word,
// binary write pointer and a registered conservative full flag

module wr_ctrl import pfifo_pkg::*; #(
    parameter int BANK_DEPTH = 1024
) (
    input  logic                                         wclock,
    input  logic                                         wreset,
    input  logic                                         we,
    input  logic [$clog2(NUM_BANKS * BANK_DEPTH):0]      rptr_sync,  // binary
    output logic                                         wr_en,
    output logic                                         wr_bank,
    output logic [$clog2(BANK_DEPTH)-1:0]                wr_addr,
    output logic                                         full
);

    localparam int ADDR_W = $clog2(BANK_DEPTH);
    localparam int TOTAL  = NUM_BANKS * BANK_DEPTH;  // words over all banks
    localparam int PTR_W  = $clog2(TOTAL) + 1;

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(BANK_DEPTH - 1);
    localparam logic [PTR_W-1:0]  FULL_LVL  = PTR_W'(TOTAL - 1);  // one word spare

    logic [PTR_W-1:0] wptr;   // binary, counts every write
    logic [PTR_W-1:0] wdiff;  // words stored as seen from wclock

    // memory write on the same edge as we
    assign wr_en = we;

    // ------------------------------------------------------------------
    // bank address and bank toggle
    // ------------------------------------------------------------------
    always_ff @(posedge wclock or negedge wreset) begin
        if (!wreset) begin
            wr_addr <= '0;
            wr_bank <= 1'b0;
        end else if (we) begin
            if (wr_addr == LAST_ADDR) begin
                wr_addr <= '0;
                wr_bank <= ~wr_bank;  // next bank
            end else begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // write pointer
    // ------------------------------------------------------------------
    always_ff @(posedge wclock or negedge wreset) begin
        if (!wreset) begin
            wptr <= '0;
        end else if (we) begin
            wptr <= wptr + 1'b1;  // wraps with the extra bit
        end
    end

    // ------------------------------------------------------------------
    // full flag
    // ------------------------------------------------------------------
    // read pointer lags, so this errs on the full side
    assign wdiff = wptr - rptr_sync;

    always_ff @(posedge wclock or negedge wreset) begin
        if (!wreset) begin
            full <= 1'b0;
        end else begin
            full <= (wdiff >= FULL_LVL);
        end
    end

endmodule

/* logic/rd_ctrl.sv */
// read side control
// first-word-fall-through head tracking over the banked storage,
// binary read pointer, complete-packet counter and registered empty
// the memory is driven with the next head address while popping

module rd_ctrl import pfifo_pkg::*; #(
    parameter int BANK_DEPTH = 1024
) (
    input  logic                                    rclock,
    input  logic                                    rreset,
    input  logic                                    re,
    input  logic                                    pkt_done,  // one per packet
    input  pkt_word_t                               rd_word,
    output logic                                    rd_bank,
    output logic [$clog2(BANK_DEPTH)-1:0]           rd_addr,
    output logic [$clog2(NUM_BANKS * BANK_DEPTH):0] rptr,      // binary
    output pkt_word_t                               rdata,
    output logic                                    empty
);

    localparam int ADDR_W = $clog2(BANK_DEPTH);
    localparam int PTR_W  = $clog2(NUM_BANKS * BANK_DEPTH) + 1;

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(BANK_DEPTH - 1);

    logic [ADDR_W-1:0] head_addr;   // address of the word on rdata
    logic              head_bank;
    logic [ADDR_W-1:0] next_addr;   // word after the head
    logic              next_bank;
    logic [PTR_W-1:0]  pkt_cnt;     // whole packets stored
    logic [PTR_W-1:0]  pkt_cnt_nxt;
    logic              eop_pop;     // popping the last word of a packet

    // ------------------------------------------------------------------
    // head address and prefetch
    // ------------------------------------------------------------------
    always_comb begin
        if (head_addr == LAST_ADDR) begin
            next_addr = '0;
            next_bank = ~head_bank;  // cross into the other bank
        end else begin
            next_addr = head_addr + 1'b1;
            next_bank = head_bank;
        end
    end

    always_ff @(posedge rclock or negedge rreset) begin
        if (!rreset) begin
            head_addr <= '0;
            head_bank <= 1'b0;
        end else if (re) begin
            head_addr <= next_addr;
            head_bank <= next_bank;
        end
    end

    // read one ahead while popping, so the new head lands one rclock later
    assign rd_addr = re ? next_addr : head_addr;
    assign rd_bank = re ? next_bank : head_bank;

    // head word straight from storage
    assign rdata = rd_word;

    // ------------------------------------------------------------------
    // read pointer, one step per pop
    // ------------------------------------------------------------------
    always_ff @(posedge rclock or negedge rreset) begin
        if (!rreset) begin
            rptr <= '0;
        end else if (re) begin
            rptr <= rptr + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // packet counter and empty
    // ------------------------------------------------------------------
    assign eop_pop = re && rd_word.eop;

    always_comb begin
        if (pkt_done && eop_pop) begin
            pkt_cnt_nxt = pkt_cnt;               // one in, one out
        end else if (pkt_done) begin
            pkt_cnt_nxt = pkt_cnt + 1'b1;
        end else if (eop_pop) begin
            pkt_cnt_nxt = pkt_cnt - 1'b1;
        end else begin
            pkt_cnt_nxt = pkt_cnt;
        end
    end

    always_ff @(posedge rclock or negedge rreset) begin
        if (!rreset) begin
            pkt_cnt <= '0;
            empty   <= 1'b1;                     // nothing whole yet
        end else begin
            pkt_cnt <= pkt_cnt_nxt;
            empty   <= (pkt_cnt_nxt == '0);
        end
    end

endmodule

/* logic/eop_crossing.sv */
// end-of-packet crossing, wclock to rclock
// each eop write holds a level for EOP_STRETCH wclock cycles,
// three rclock flops sample it and a rising edge gives pkt_done

module eop_crossing import pfifo_pkg::*; (
    input  logic wclock,
    input  logic wreset,
    input  logic rclock,
    input  logic rreset,
    input  logic we,
    input  logic eop_in,    // eop flag of the word being written
    output logic pkt_done   // one rclock per packet
);

    localparam int CNT_W = $clog2(EOP_STRETCH);

    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(EOP_STRETCH - 1);

    logic             stretch;      // held eop level, wclock
    logic [CNT_W-1:0] stretch_cnt;
    logic             sync1;        // rclock synchroniser
    logic             sync2;
    logic             sync3;        // edge reference

    // ------------------------------------------------------------------
    // wclock side, pulse stretch
    // ------------------------------------------------------------------
    always_ff @(posedge wclock or negedge wreset) begin
        if (!wreset) begin
            stretch     <= 1'b0;
            stretch_cnt <= '0;
        end else if (stretch) begin
            if (stretch_cnt == LAST_CNT) begin
                stretch     <= 1'b0;  // a new eop here is lost
                stretch_cnt <= '0;
            end else begin
                stretch_cnt <= stretch_cnt + 1'b1;
            end
        end else if (we && eop_in) begin
            stretch <= 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // rclock side, sync and edge detect
    // ------------------------------------------------------------------
    always_ff @(posedge rclock or negedge rreset) begin
        if (!rreset) begin
            sync1 <= 1'b0;
            sync2 <= 1'b0;
            sync3 <= 1'b0;
        end else begin
            sync1 <= stretch;  // only flop that sees the async level
            sync2 <= sync1;
            sync3 <= sync2;
        end
    end

    assign pkt_done = sync2 && !sync3;  // rising edge

endmodule

/* logic/ptr_crossing.sv */
// read pointer crossing, rclock to wclock
// binary pointer goes to Gray in rclock, two wclock flops,
// then back to binary and registered for the full compare

module ptr_crossing import pfifo_pkg::*; #(
    parameter int BANK_DEPTH = 1024
) (
    input  logic                                    rclock,
    input  logic                                    rreset,
    input  logic                                    wclock,
    input  logic                                    wreset,
    input  logic [$clog2(NUM_BANKS * BANK_DEPTH):0] rptr,       // binary, rclock
    output logic [$clog2(NUM_BANKS * BANK_DEPTH):0] rptr_sync   // binary, wclock
);

    localparam int PTR_W = $clog2(NUM_BANKS * BANK_DEPTH) + 1;

    logic [PTR_W-1:0] rptr_gray;   // rclock register, one bit moves per pop
    logic [PTR_W-1:0] gray_d1;     // wclock stage 1
    logic [PTR_W-1:0] gray_d2;     // wclock stage 2
    logic [PTR_W-1:0] bin_comb;

    // ------------------------------------------------------------------
    // rclock side
    // ------------------------------------------------------------------
    always_ff @(posedge rclock or negedge rreset) begin
        if (!rreset) begin
            rptr_gray <= '0;
        end else begin
            rptr_gray <= rptr ^ (rptr >> 1);
        end
    end

    // ------------------------------------------------------------------
    // wclock side
    // ------------------------------------------------------------------
    always_ff @(posedge wclock or negedge wreset) begin
        if (!wreset) begin
            gray_d1   <= '0;
            gray_d2   <= '0;
            rptr_sync <= '0;
        end else begin
            gray_d1   <= rptr_gray;
            gray_d2   <= gray_d1;
            rptr_sync <= bin_comb;  // breaks the xor chain
        end
    end

    // gray to binary, msb down
    always_comb begin
        bin_comb[PTR_W-1] = gray_d2[PTR_W-1];
        for (int i = PTR_W - 2; i >= 0; i--) begin
            bin_comb[i] = bin_comb[i+1] ^ gray_d2[i];
        end
    end

endmodule

/* logic/pfifo_top.sv */
// dual-clock packet FIFO
// writer pushes packet words in wclock, reader pops them in rclock
// empty stays high until a whole packet is stored
// full is a conservative level from the synchronised read pointer

module pfifo_top import pfifo_pkg::*; #(
    parameter int BANK_DEPTH = 1024  // words per bank, power of two
) (
    input  logic      wclock,
    input  logic      wreset,   // async, active low
    input  logic      rclock,
    input  logic      rreset,   // async, active low
    input  logic      we,       // one strobe per word
    input  pkt_word_t wdata,
    input  logic      re,       // one strobe per popped word
    output pkt_word_t rdata,    // head word
    output logic      full,     // wclock domain
    output logic      empty     // rclock domain
);

    localparam int ADDR_W = $clog2(BANK_DEPTH);
    localparam int PTR_W  = $clog2(NUM_BANKS * BANK_DEPTH) + 1;  // one extra wrap bit

    // write side to storage
    logic              wr_en;
    logic              wr_bank;
    logic [ADDR_W-1:0] wr_addr;

    // read side to storage
    logic              rd_bank;
    logic [ADDR_W-1:0] rd_addr;
    pkt_word_t         rd_word;

    // crossings
    logic [PTR_W-1:0]  rptr;       // binary, rclock
    logic [PTR_W-1:0]  rptr_sync;  // binary, wclock
    logic              pkt_done;   // one rclock per packet

    // ------------------------------------------------------------------
    // write domain
    // ------------------------------------------------------------------
    wr_ctrl #(.BANK_DEPTH(BANK_DEPTH)) u_wr_ctrl (
        .wclock    (wclock),
        .wreset    (wreset),
        .we        (we),
        .rptr_sync (rptr_sync),
        .wr_en     (wr_en),
        .wr_bank   (wr_bank),
        .wr_addr   (wr_addr),
        .full      (full)
    );

    // ------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------
    pkt_ram_bank #(.BANK_DEPTH(BANK_DEPTH)) u_ram (
        .wclock  (wclock),
        .rclock  (rclock),
        .wr_en   (wr_en),
        .wr_bank (wr_bank),
        .wr_addr (wr_addr),
        .wr_word (wdata),
        .rd_bank (rd_bank),
        .rd_addr (rd_addr),
        .rd_word (rd_word)
    );

    // ------------------------------------------------------------------
    // read domain
    // ------------------------------------------------------------------
    rd_ctrl #(.BANK_DEPTH(BANK_DEPTH)) u_rd_ctrl (
        .rclock   (rclock),
        .rreset   (rreset),
        .re       (re),
        .pkt_done (pkt_done),
        .rd_word  (rd_word),
        .rd_bank  (rd_bank),
        .rd_addr  (rd_addr),
        .rptr     (rptr),
        .rdata    (rdata),
        .empty    (empty)
    );

    // eop level across to the read side, gives the packet count
    eop_crossing u_eop_crossing (
        .wclock   (wclock),
        .wreset   (wreset),
        .rclock   (rclock),
        .rreset   (rreset),
        .we       (we),
        .eop_in   (wdata.eop),
        .pkt_done (pkt_done)
    );

    // read pointer across to the write side, gives full
    ptr_crossing #(.BANK_DEPTH(BANK_DEPTH)) u_ptr_crossing (
        .rclock    (rclock),
        .rreset    (rreset),
        .wclock    (wclock),
        .wreset    (wreset),
        .rptr      (rptr),
        .rptr_sync (rptr_sync)
    );

endmodule

/* tb/tb_clock.sv */
// testbench clock source
// free-running square wave, first rising edge at START

module tb_clock #(
    parameter int PERIOD = 8,
    parameter int START  = 0   // time of first rising edge
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        #(START);
        forever begin
            clk = 1'b1;
            #(PERIOD / 2);
            clk = 1'b0;
            #(PERIOD - PERIOD / 2);  // odd periods keep their length
        end
    end

endmodule

/* tb/tb_pfifo.sv */
// packet FIFO testbench
// random packets through the dual-clock FIFO, read back against a
// reference queue, with checks on empty and full timing

module tb_pfifo import pfifo_pkg::*; ();

    localparam int DEPTH      = 16;                    // words per bank
    localparam int FULL_SAFE  = 28;                    // full stays low below this
    localparam int FILL_WORDS = NUM_BANKS * DEPTH - 1; // fill for the full test

    logic      wclock;
    logic      rclock;
    logic      wreset;
    logic      rreset;
    logic      we;
    logic      re;
    logic      full;
    logic      empty;
    pkt_word_t wdata;
    pkt_word_t rdata;

    pkt_word_t ref_q[$];    // written, not yet popped
    int        pkt_len[$];  // planned packet lengths, all tests
    int        err_cnt;
    int        pass_cnt;
    int        fail_cnt;
    int        word_cnt;    // words compared
    int        wr_cnt;      // words written so far
    int        rd_cnt;      // words popped so far
    int        cycle_limit;
    int        wd_cycles;
    bit        full_watch;

    tb_clock #(.PERIOD(8), .START(4)) u_wclk (.clk(wclock));
    tb_clock #(.PERIOD(8), .START(7)) u_rclk (.clk(rclock));  // 3 units behind

    pfifo_top #(.BANK_DEPTH(DEPTH)) uut (
        .wclock (wclock),
        .wreset (wreset),
        .rclock (rclock),
        .rreset (rreset),
        .we     (we),
        .wdata  (wdata),
        .re     (re),
        .rdata  (rdata),
        .full   (full),
        .empty  (empty)
    );

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------
    function automatic pkt_word_t make_word(input int idx, input int len);
        pkt_word_t w;
        w.sop  = (idx == 0);
        w.eop  = (idx == len - 1);
        w.data = DATA_W'($urandom);
        return w;
    endfunction

    function automatic int rand_len();
        return 2 + int'($urandom % 11);  // 2 to 12 words
    endfunction

    // one word, held back while full
    task automatic write_word(input pkt_word_t w);
        @(posedge wclock);
        while (full) begin
            we <= 1'b0;
            @(posedge wclock);
        end
        we    <= 1'b1;
        wdata <= w;
        ref_q.push_back(w);
    endtask

    task automatic end_writes();
        @(posedge wclock);
        we <= 1'b0;  // last word lands on this edge
    endtask

    // idle ahead of each packet keeps eop writes EOP_GAP apart
    task automatic send_packet(input int len);
        repeat (EOP_GAP) @(posedge wclock);
        for (int i = 0; i < len; i++) begin
            write_word(make_word(i, len));
        end
        end_writes();
    endtask

    // waits for a whole packet, pops through its eop, compares each word
    task automatic pop_packet();
        pkt_word_t exp;
        bit        last;
        @(posedge rclock);
        while (empty) @(posedge rclock);
        re   <= 1'b1;
        last = 1'b0;
        while (!last) begin
            @(posedge rclock);  // pop happens on this edge
            if (ref_q.size() == 0) begin
                err_cnt++;
                $display("reader popped at %0t with nothing left to compare", $time);
                last = 1'b1;
            end else begin
                exp  = ref_q.pop_front();
                last = exp.eop;
                word_cnt++;
                assert (rdata === exp) else begin
                    err_cnt++;
                    $display("Fail at %0t: popped sop=%0b eop=%0b data=%h, %s %0b %0b %h",
                             $time, rdata.sop, rdata.eop, rdata.data,
                             "expected", exp.sop, exp.eop, exp.data);
                end
            end
        end
        re <= 1'b0;
    endtask

    task automatic wait_empty_level(input bit level, input int limit, output bit hit);
        hit = 1'b0;
        for (int i = 0; i < limit && !hit; i++) begin
            @(posedge rclock);
            hit = (empty == level);
        end
    endtask

    task automatic wait_full_level(input bit level, input int limit, output bit hit);
        hit = 1'b0;
        for (int i = 0; i < limit && !hit; i++) begin
            @(posedge wclock);
            hit = (full == level);
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %0d %s: ok", num, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: %0d errors", num, name, err_cnt - errs_before);
        end
    endtask

    // ----------------------------------------------------------------------
    // monitors
    // ----------------------------------------------------------------------
    always @(posedge wclock) begin
        if (we) wr_cnt <= wr_cnt + 1;
    end

    always @(posedge rclock) begin
        if (re) rd_cnt <= rd_cnt + 1;
    end

    // full may lag, but must never lead
    always @(posedge wclock) begin
        if (full_watch) begin
            assert (!(full && (wr_cnt - rd_cnt) < FULL_SAFE)) else begin
                err_cnt++;
                $display("Fail at %0t: full high with %0d words stored", $time,
                         wr_cnt - rd_cnt);
            end
        end
    end

    // watchdog
    initial begin
        wait (cycle_limit > 0);
        wd_cycles = 0;
        while (wd_cycles < cycle_limit) begin
            @(posedge wclock);
            wd_cycles++;
        end
        $display("timeout: run still going after %0d wclock cycles", cycle_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        int        n4;
        int        n5;
        int        sum;
        int        rem;
        int        len;
        int        base;
        int        errs;
        bit        hit;
        void'($urandom(17698));
        we         = 1'b0;
        re         = 1'b0;
        wdata      = '0;
        wreset     = 1'b0;
        rreset     = 1'b0;
        full_watch = 1'b1;

        // packet plan: one for tests 1-2, two for test 3, then 4 and 5
        for (int i = 0; i < 3; i++) pkt_len.push_back(rand_len());
        sum = 0;
        n4  = 0;
        while (sum <= 40) begin  // enough to wrap both banks
            len = rand_len();
            pkt_len.push_back(len);
            sum += len;
            n4++;
        end
        rem = FILL_WORDS;
        n5  = 0;
        while (rem > 0) begin
            if (rem <= 12) begin
                len = rem;
            end else begin
                len = rand_len();
                if (rem - len == 1) len--;  // no 1-word tail
            end
            pkt_len.push_back(len);
            rem -= len;
            n5++;
        end
        sum = 0;
        foreach (pkt_len[i]) sum += pkt_len[i];
        cycle_limit = 2 * (sum + EOP_GAP * pkt_len.size()) + 200;

        fork
            begin
                repeat (2) @(posedge wclock);
                wreset <= 1'b1;
            end
            begin
                repeat (2) @(posedge rclock);
                rreset <= 1'b1;
            end
        join

        // 1: reset levels, then a packet without its eop
        errs = err_cnt;
        @(posedge rclock);
        assert (empty) else begin
            err_cnt++;
            $display("Fail at %0t: empty low right after reset", $time);
        end
        @(posedge wclock);
        assert (!full) else begin
            err_cnt++;
            $display("Fail at %0t: full high right after reset", $time);
        end
        repeat (EOP_GAP) @(posedge wclock);
        for (int i = 0; i < pkt_len[0] - 1; i++) write_word(make_word(i, pkt_len[0]));
        end_writes();
        repeat (16) begin
            @(posedge rclock);
            assert (empty) else begin
                err_cnt++;
                $display("Fail at %0t: empty fell before any eop was written", $time);
            end
        end
        report_test(1, "reset and partial packet", errs);

        // 2: finish the packet, read it back
        errs = err_cnt;
        write_word(make_word(pkt_len[0] - 1, pkt_len[0]));
        end_writes();
        wait_empty_level(1'b0, 10, hit);
        assert (hit) else begin
            err_cnt++;
            $display("empty did not fall within 10 rclock cycles of the eop write");
        end
        pop_packet();
        @(posedge rclock);
        assert (empty) else begin
            err_cnt++;
            $display("Fail at %0t: empty still low after the only packet was popped",
                     $time);
        end
        report_test(2, "single packet", errs);

        // 3: two stored packets, empty stays low between them
        errs = err_cnt;
        send_packet(pkt_len[1]);
        send_packet(pkt_len[2]);
        repeat (8) @(posedge rclock);  // second eop through the crossing
        pop_packet();
        @(posedge rclock);
        assert (!empty) else begin
            err_cnt++;
            $display("Fail at %0t: empty rose with a whole packet still stored", $time);
        end
        pop_packet();
        @(posedge rclock);
        assert (empty) else begin
            err_cnt++;
            $display("Fail at %0t: empty still low after the last packet was popped",
                     $time);
        end
        report_test(3, "back to back packets", errs);

        // 4: reads alongside writes, several bank wraps
        errs = err_cnt;
        fork
            for (int p = 3; p < 3 + n4; p++) send_packet(pkt_len[p]);
            repeat (n4) pop_packet();
        join
        assert (ref_q.size() == 0) else begin
            err_cnt++;
            $display("%0d words left unread after the streaming test", ref_q.size());
        end
        report_test(4, "streaming across banks", errs);

        // 5: fill to full, free one packet, drain
        errs = err_cnt;
        base = 3 + n4;
        for (int p = base; p < base + n5; p++) send_packet(pkt_len[p]);
        wait_full_level(1'b1, 8, hit);
        assert (hit) else begin
            err_cnt++;
            $display("full did not rise within 8 wclock cycles of the last write");
        end
        full_watch = 1'b0;  // pointer lag keeps full up during the pop
        pop_packet();
        wait_full_level(1'b0, 8, hit);
        assert (hit) else begin
            err_cnt++;
            $display("full did not fall within 8 wclock cycles of a packet pop");
        end
        full_watch = 1'b1;
        repeat (n5 - 1) pop_packet();
        assert (ref_q.size() == 0) else begin
            err_cnt++;
            $display("%0d words left unread after the drain", ref_q.size());
        end
        report_test(5, "full flag", errs);

        $display("summary: %0d tests passed, %0d failed, %0d errors, %0d words checked",
                 pass_cnt, fail_cnt, err_cnt, word_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* project.f */
logic/pfifo_pkg.sv
logic/pkt_ram_bank.sv
logic/wr_ctrl.sv
logic/rd_ctrl.sv
logic/eop_crossing.sv
logic/ptr_crossing.sv
logic/pfifo_top.sv
tb/tb_clock.sv
tb/tb_pfifo.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the packet FIFO testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=tb_pfifo_sim
LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_pfifo \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
